// File: compile.f
hw/rv_pkg.sv
hw/alu.sv
hw/decode.sv
hw/execute.sv
hw/reg_file.sv
hw/exec_unit.sv
verif/exec_unit_properties.sv
verif/exec_unit_tb.sv

// File: hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import rv_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  alu_func_e func,
  output word_t     out
);
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits count for RV32 shifts
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (func)
      ADD:  out = a + b;
      SUB:  out = a - b;
      AND:  out = a & b;
      OR:   out = a | b;
      XOR:  out = a ^ b;
      SLT:  out = {{(xlen-1){1'b0}}, lt_signed};
      SLTU: out = {{(xlen-1){1'b0}}, lt_unsigned};
      SLL:  out = a << shamt;
      SRL:  out = a >> shamt;
      // Arithmetic shift keeps the sign bit
      SRA:  out = word_t'($signed(a) >>> shamt);
      default: begin
        out = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode import rv_pkg::*; (
  input  inst_t     instr,
  output itype_e    itype,
  output alu_func_e alu_func,
  output br_func_e  br_func,
  output mem_func_e mem_func,
  output word_t     imm,
  output reg_idx_t  rs1,
  output reg_idx_t  rs2,
  output reg_idx_t  dst,
  output logic      dst_valid
);
  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_b;
  word_t     imm_u;
  word_t     imm_j;
  logic      use_alt;
  logic      op_ok;
  logic      opimm_ok;
  alu_func_e op_func;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Register fields sit at fixed positions in every format
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign dst = instr[11:7];

  // Immediate formats, sign taken from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct7 bit 5 picks SUB/SRA; for immediates only SRAI carries it
  assign use_alt = funct7[5] && (opcode == opc_op || funct3 == f3_sr);

  // Legal funct7 values for register and immediate ALU ops
  assign op_ok = (funct7 == f7_base) ||
                 (funct7 == f7_alt && (funct3 == f3_add || funct3 == f3_sr));
  assign opimm_ok = (funct3 != f3_sll && funct3 != f3_sr) ||
                    (funct7 == f7_base) ||
                    (funct7 == f7_alt && funct3 == f3_sr);

  always_comb begin
    case (funct3)
      f3_add:  op_func = use_alt ? SUB : ADD;
      f3_sll:  op_func = SLL;
      f3_slt:  op_func = SLT;
      f3_sltu: op_func = SLTU;
      f3_xor:  op_func = XOR;
      f3_sr:   op_func = use_alt ? SRA : SRL;
      f3_or:   op_func = OR;
      default: op_func = AND;
    endcase
  end

  always_comb begin
    itype    = UNSUP;
    alu_func = ADD;
    br_func  = NONE;
    mem_func = MNONE;
    imm      = '0;
    case (opcode)
      opc_op: begin
        alu_func = op_func;
        if (op_ok) itype = OP;
      end
      opc_opimm: begin
        alu_func = op_func;
        imm      = imm_i;
        if (opimm_ok) itype = OPIMM;
      end
      opc_lui: begin
        itype = LUI;
        imm   = imm_u;
      end
      opc_auipc: begin
        itype = AUIPC;
        imm   = imm_u;
      end
      opc_jal: begin
        itype = JAL;
        imm   = imm_j;
      end
      opc_jalr: begin
        imm = imm_i;
        if (funct3 == 3'b000) itype = JALR;
      end
      opc_branch: begin
        imm   = imm_b;
        itype = BRANCH;
        case (funct3)
          f3_beq:  br_func = EQ;
          f3_bne:  br_func = NEQ;
          f3_blt:  br_func = LT;
          f3_bge:  br_func = GE;
          f3_bltu: br_func = LTU;
          f3_bgeu: br_func = GEU;
          default: itype = UNSUP;
        endcase
      end
      opc_load: begin
        imm   = imm_i;
        itype = LOAD;
        case (funct3)
          f3_b:    mem_func = LB;
          f3_h:    mem_func = LH;
          f3_w:    mem_func = LW;
          f3_bu:   mem_func = LBU;
          f3_hu:   mem_func = LHU;
          default: itype = UNSUP;
        endcase
      end
      opc_store: begin
        imm   = imm_s;
        itype = STORE;
        case (funct3)
          f3_b:    mem_func = SB;
          f3_h:    mem_func = SH;
          f3_w:    mem_func = SW;
          default: itype = UNSUP;
        endcase
      end
      default: begin
        itype = UNSUP;
      end
    endcase
  end

  // Loads never write back here since there is no data memory
  assign dst_valid = itype inside {OP, OPIMM, LUI, AUIPC, JAL, JALR};

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      instr_valid,
  input  inst_t     instr,
  input  word_t     pc,
  output logic      result_valid,
  output logic      wb_en,
  output reg_idx_t  wb_dst,
  output word_t     wb_data,
  output word_t     mem_addr,
  output mem_func_e mem_func_out,
  output word_t     next_pc
);
  itype_e    itype;
  alu_func_e alu_func;
  br_func_e  br_func;
  mem_func_e mem_func;
  word_t     imm;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  dst;
  logic      dst_valid;
  word_t     r_val1;
  word_t     r_val2;
  word_t     ex_data;
  word_t     ex_addr;
  word_t     ex_next_pc;
  logic      we;

  decode decode_i (
    .instr     (instr),
    .itype     (itype),
    .alu_func  (alu_func),
    .br_func   (br_func),
    .mem_func  (mem_func),
    .imm       (imm),
    .rs1       (rs1),
    .rs2       (rs2),
    .dst       (dst),
    .dst_valid (dst_valid)
  );

  // Write lands at the same edge the result is registered
  assign we = instr_valid && dst_valid && (dst != '0);

  reg_file reg_file_i (
    .clk    (clk),
    .rst    (rst),
    .rs1    (rs1),
    .rs2    (rs2),
    .r_val1 (r_val1),
    .r_val2 (r_val2),
    .we     (we),
    .wa     (dst),
    .wd     (ex_data)
  );

  execute execute_i (
    .itype    (itype),
    .alu_func (alu_func),
    .br_func  (br_func),
    .imm      (imm),
    .r_val1   (r_val1),
    .r_val2   (r_val2),
    .pc       (pc),
    .data     (ex_data),
    .addr     (ex_addr),
    .next_pc  (ex_next_pc)
  );

  // Control outputs
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      wb_en        <= 1'b0;
      mem_func_out <= MNONE;
    end else begin
      result_valid <= instr_valid;
      wb_en        <= we;
      if (instr_valid) mem_func_out <= mem_func;
    end
  end

  // Result payload, held between strobes
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      wb_dst   <= dst;
      wb_data  <= ex_data;
      mem_addr <= ex_addr;
      next_pc  <= ex_next_pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/execute.sv
`timescale 1ns/10ps
`default_nettype none

// Branch condition check
module br_alu import rv_pkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  br_func_e br_func,
  output logic     taken
);
  always_comb begin
    case (br_func)
      EQ:  taken = (a == b);
      NEQ: taken = (a != b);
      LT:  taken = ($signed(a) < $signed(b));
      LTU: taken = (a < b);
      GE:  taken = ($signed(a) >= $signed(b));
      GEU: taken = (a >= b);
      // NONE and anything else falls through
      default: begin
        taken = 1'b0;
      end
    endcase
  end
endmodule

module execute import rv_pkg::*; (
  input  itype_e    itype,
  input  alu_func_e alu_func,
  input  br_func_e  br_func,
  input  word_t     imm,
  input  word_t     r_val1,
  input  word_t     r_val2,
  input  word_t     pc,
  output word_t     data,
  output word_t     addr,
  output word_t     next_pc
);
  word_t alu_b;
  word_t alu_out;
  word_t pc_plus_4;
  word_t pc_plus_imm;
  logic  taken;

  // Immediate ops take imm as the second operand
  assign alu_b = (itype == OPIMM) ? imm : r_val2;

  assign pc_plus_4   = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  // Memory address and JALR target share this sum
  assign addr = r_val1 + imm;

  alu alu_i (
    .a    (r_val1),
    .b    (alu_b),
    .func (alu_func),
    .out  (alu_out)
  );

  br_alu br_alu_i (
    .a       (r_val1),
    .b       (r_val2),
    .br_func (br_func),
    .taken   (taken)
  );

  // Write-back or store data
  always_comb begin
    case (itype)
      AUIPC:     data = pc_plus_imm;
      LUI:       data = imm;
      OP, OPIMM: data = alu_out;
      JAL, JALR: data = pc_plus_4;
      STORE:     data = r_val2;
      default: begin
        data = '0;
      end
    endcase
  end

  always_comb begin
    case (itype)
      BRANCH:  next_pc = taken ? pc_plus_imm : pc_plus_4;
      JAL:     next_pc = pc_plus_imm;
      // Target is always halfword aligned
      JALR:    next_pc = {addr[xlen-1:1], 1'b0};
      default: begin
        next_pc = pc_plus_4;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    r_val1,
  output word_t    r_val2,
  input  logic     we,
  input  reg_idx_t wa,
  input  word_t    wd
);
  // x0 has no storage
  word_t regs [1:reg_count-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;
    end
  end

  // Combinational reads, zero for index 0
  always_comb begin
    if (rs1 == '0) r_val1 = '0;
    else           r_val1 = regs[rs1];
  end

  always_comb begin
    if (rs2 == '0) r_val2 = '0;
    else           r_val2 = regs[rs2];
  end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
package rv_pkg;

  // Datapath dimensions
  localparam int xlen      = 32;
  localparam int ilen      = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0]              word_t;
  typedef logic [ilen-1:0]              inst_t;
  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

  // Instruction word fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Instruction class
  typedef enum logic [3:0] {
    OP, OPIMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, UNSUP
  } itype_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
  } alu_func_e;

  typedef enum logic [2:0] {
    EQ, NEQ, LT, LTU, GE, GEU, NONE
  } br_func_e;

  // Nine codes, so this one needs a fourth bit
  typedef enum logic [3:0] {
    LB, LH, LW, LBU, LHU, SB, SH, SW, MNONE
  } mem_func_e;

  // Major opcodes
  localparam opcode_t opc_op     = 7'b0110011;
  localparam opcode_t opc_opimm  = 7'b0010011;
  localparam opcode_t opc_lui    = 7'b0110111;
  localparam opcode_t opc_auipc  = 7'b0010111;
  localparam opcode_t opc_jal    = 7'b1101111;
  localparam opcode_t opc_jalr   = 7'b1100111;
  localparam opcode_t opc_branch = 7'b1100011;
  localparam opcode_t opc_load   = 7'b0000011;
  localparam opcode_t opc_store  = 7'b0100011;

  // funct7 for register ops; alt selects SUB and SRA
  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

  // funct3 for OP and OPIMM
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // funct3 for branches
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // funct3 for loads and stores (size and sign)
  localparam funct3_t f3_b  = 3'b000;
  localparam funct3_t f3_h  = 3'b001;
  localparam funct3_t f3_w  = 3'b010;
  localparam funct3_t f3_bu = 3'b100;
  localparam funct3_t f3_hu = 3'b101;

endpackage

// File: verif/exec_unit_properties.sv
`timescale 1ns/10ps

module exec_unit_properties import rv_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     instr_valid,
  input logic     result_valid,
  input logic     wb_en,
  input reg_idx_t wb_dst
);

  // One cycle from strobe to result
  property valid_follows_strobe;
    @(posedge clk) disable iff (rst)
      !$past(rst) |-> (result_valid == $past(instr_valid));
  endproperty

  property quiet_after_reset;
    @(posedge clk) (rst ##1 !rst) |-> !result_valid;
  endproperty

  // A reported write always targets a real register
  property write_is_valid;
    @(posedge clk) disable iff (rst)
      wb_en |-> (result_valid && wb_dst != '0);
  endproperty

  valid_follows_strobe_a : assert property (valid_follows_strobe)
    else $error("result_valid does not follow instr_valid by one cycle");
  quiet_after_reset_a : assert property (quiet_after_reset)
    else $error("result_valid high in the cycle after reset");
  write_is_valid_a : assert property (write_is_valid)
    else $error("wb_en without result_valid or with wb_dst zero");

endmodule

bind exec_unit exec_unit_properties props_i (
  .clk          (clk),
  .rst          (rst),
  .instr_valid  (instr_valid),
  .result_valid (result_valid),
  .wb_en        (wb_en),
  .wb_dst       (wb_dst)
);

// File: verif/exec_unit_tb.sv
`timescale 1ns/10ps

module exec_unit_tb import rv_pkg::*; ();
  localparam int reset_cycles = 3;

  logic      clk;
  logic      rst;
  logic      instr_valid;
  inst_t     instr;
  word_t     pc;
  logic      result_valid;
  logic      wb_en;
  reg_idx_t  wb_dst;
  word_t     wb_data;
  word_t     mem_addr;
  mem_func_e mem_func_out;
  word_t     next_pc;

  // Stimulus and expected results, one entry per instruction
  string     name_q[$];
  inst_t     instr_q[$];
  word_t     pc_q[$];
  logic      en_q[$];
  reg_idx_t  dst_q[$];
  word_t     data_q[$];
  word_t     addr_q[$];
  mem_func_e mf_q[$];
  word_t     npc_q[$];

  int error_count = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  exec_unit dut_i (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc           (pc),
    .result_valid (result_valid),
    .wb_en        (wb_en),
    .wb_dst       (wb_dst),
    .wb_data      (wb_data),
    .mem_addr     (mem_addr),
    .mem_func_out (mem_func_out),
    .next_pc      (next_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Instruction encoders
  function automatic inst_t r_type(funct7_t f7, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                   reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic inst_t i_type(opcode_t opc, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                   logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t s_type(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic inst_t b_type(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic inst_t u_type(opcode_t opc, reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t j_type(reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  // pc advances by 4 for every entry, starting at 0x100
  task automatic add_test(input string name, input inst_t ins, input logic en,
                          input reg_idx_t dst, input word_t data, input word_t addr,
                          input mem_func_e mf, input word_t npc);
    pc_q.push_back(32'h100 + 4 * instr_q.size());
    name_q.push_back(name);
    instr_q.push_back(ins);
    en_q.push_back(en);
    dst_q.push_back(dst);
    data_q.push_back(data);
    addr_q.push_back(addr);
    mf_q.push_back(mf);
    npc_q.push_back(npc);
  endtask

  task automatic build_table();
    // x1 = 5, x2 = -3, then ALU ops chain on them
    add_test("addi", i_type(opc_opimm, f3_add, 1, 0, 12'd5), 1, 1, 32'h5, 32'h5, MNONE,
             32'h104);
    add_test("addi_neg", i_type(opc_opimm, f3_add, 2, 0, 12'hffd), 1, 2, 32'hfffffffd,
             32'hfffffffd, MNONE, 32'h108);
    add_test("add", r_type(f7_base, f3_add, 3, 1, 2), 1, 3, 32'h2, 32'h5, MNONE, 32'h10c);
    add_test("sub", r_type(f7_alt, f3_add, 4, 1, 2), 1, 4, 32'h8, 32'h5, MNONE, 32'h110);
    add_test("and", r_type(f7_base, f3_and, 5, 1, 2), 1, 5, 32'h5, 32'h5, MNONE, 32'h114);
    add_test("or", r_type(f7_base, f3_or, 6, 1, 2), 1, 6, 32'hfffffffd, 32'h5, MNONE,
             32'h118);
    add_test("xor", r_type(f7_base, f3_xor, 7, 1, 2), 1, 7, 32'hfffffff8, 32'h5, MNONE,
             32'h11c);
    add_test("slt", r_type(f7_base, f3_slt, 8, 2, 1), 1, 8, 32'h1, 32'hfffffffd, MNONE,
             32'h120);
    add_test("sltu", r_type(f7_base, f3_sltu, 9, 2, 1), 1, 9, 32'h0, 32'hfffffffd, MNONE,
             32'h124);
    add_test("sll", r_type(f7_base, f3_sll, 10, 1, 4), 1, 10, 32'h500, 32'h5, MNONE, 32'h128);
    add_test("srl", r_type(f7_base, f3_sr, 11, 2, 1), 1, 11, 32'h07ffffff, 32'hfffffffd,
             MNONE, 32'h12c);
    add_test("sra", r_type(f7_alt, f3_sr, 12, 2, 1), 1, 12, 32'hffffffff, 32'hfffffffd,
             MNONE, 32'h130);
    add_test("lui", u_type(opc_lui, 13, 20'h12300), 1, 13, 32'h12300000, 32'h12300000,
             MNONE, 32'h134);
    add_test("auipc", u_type(opc_auipc, 14, 20'h1), 1, 14, 32'h1134, 32'h1000, MNONE, 32'h138);
    // Signed and unsigned order of x1 and x2 disagree
    add_test("beq_t", b_type(f3_beq, 1, 1, 13'd16), 0, 0, 32'h0, 32'h15, MNONE, 32'h148);
    add_test("beq_n", b_type(f3_beq, 1, 2, 13'd16), 0, 0, 32'h0, 32'h15, MNONE, 32'h140);
    add_test("bne_t", b_type(f3_bne, 1, 2, 13'h1ff8), 0, 0, 32'h0, 32'hfffffffd, MNONE,
             32'h138);
    add_test("bne_n", b_type(f3_bne, 1, 1, 13'h1ff8), 0, 0, 32'h0, 32'hfffffffd, MNONE,
             32'h148);
    add_test("blt_t", b_type(f3_blt, 2, 1, 13'd32), 0, 0, 32'h0, 32'h1d, MNONE, 32'h168);
    add_test("bltu_n", b_type(f3_bltu, 2, 1, 13'd32), 0, 0, 32'h0, 32'h1d, MNONE, 32'h150);
    add_test("bge_n", b_type(f3_bge, 2, 1, 13'd32), 0, 0, 32'h0, 32'h1d, MNONE, 32'h154);
    add_test("bgeu_t", b_type(f3_bgeu, 2, 1, 13'd32), 0, 0, 32'h0, 32'h1d, MNONE, 32'h174);
    add_test("blt_n", b_type(f3_blt, 1, 2, 13'd32), 0, 0, 32'h0, 32'h25, MNONE, 32'h15c);
    add_test("bltu_t", b_type(f3_bltu, 1, 2, 13'd32), 0, 0, 32'h0, 32'h25, MNONE, 32'h17c);
    add_test("bge_t", b_type(f3_bge, 1, 2, 13'd32), 0, 0, 32'h0, 32'h25, MNONE, 32'h180);
    add_test("bgeu_n", b_type(f3_bgeu, 1, 2, 13'd32), 0, 0, 32'h0, 32'h25, MNONE, 32'h168);
    add_test("jal", j_type(15, 21'h40), 1, 15, 32'h16c, 32'h40, MNONE, 32'h1a8);
    // Odd target, bit 0 must drop
    add_test("jalr", i_type(opc_jalr, 3'b000, 16, 4, 12'h101), 1, 16, 32'h170, 32'h109,
             MNONE, 32'h108);
    add_test("sw", s_type(f3_w, 10, 7, 12'd12), 0, 0, 32'hfffffff8, 32'h50c, SW, 32'h174);
    add_test("lw", i_type(opc_load, f3_w, 17, 10, 12'hffc), 0, 0, 32'h0, 32'h4fc, LW, 32'h178);
    add_test("addi_x0", i_type(opc_opimm, f3_add, 0, 1, 12'd7), 0, 0, 32'hc, 32'hc, MNONE,
             32'h17c);
    add_test("read_x0", r_type(f7_base, f3_add, 18, 0, 1), 1, 18, 32'h5, 32'h0, MNONE,
             32'h180);
    // x17 stays zero after the load, x16 holds the JALR link
    add_test("link_chk", r_type(f7_base, f3_add, 19, 17, 16), 1, 19, 32'h170, 32'h0, MNONE,
             32'h184);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_mem_func(input string name, input mem_func_e got, input mem_func_e exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_test(input int i);
    int errs_before;
    errs_before = error_count;
    if (result_valid !== 1'b1) begin
      $display("Test %0d (%s): result_valid did not rise one cycle after the strobe",
               i, name_q[i]);
      error_count++;
    end
    check_flag("wb_en", wb_en, en_q[i]);
    // Destination only matters when a write is reported
    if (en_q[i]) begin
      check_reg_idx("wb_dst", wb_dst, dst_q[i]);
    end
    check_word("wb_data", wb_data, data_q[i]);
    check_word("mem_addr", mem_addr, addr_q[i]);
    check_mem_func("mem_func_out", mem_func_out, mf_q[i]);
    check_word("next_pc", next_pc, npc_q[i]);
    if (error_count == errs_before) begin
      pass_count++;
      $display("PASS test %0d %s", i, name_q[i]);
    end else begin
      fail_count++;
      $display("FAIL test %0d %s", i, name_q[i]);
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run stopped after %0d cycles without finishing the table", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    build_table();
    cycle_limit = instr_q.size() + reset_cycles + 20;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    // Back to back, each result checked while the next entry is driven
    for (int i = 0; i < instr_q.size(); i++) begin
      instr_valid = 1'b1;
      instr       = instr_q[i];
      pc          = pc_q[i];
      @(posedge clk);
      #1;
      check_test(i);
    end
    instr_valid = 1'b0;
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             instr_q.size(), pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
